//--- include/vis_config.svh
`ifndef VIS_CONFIG_SVH
`define VIS_CONFIG_SVH

// ------------------------------------------------------------
// correlator geometry
// ------------------------------------------------------------
`define VIS_CORRS  4                       // correlators in the bank
`define VIS_MRATE  3                       // time-multiplexed slots per correlator
`define VIS_COUNT  (`VIS_CORRS * 2 * `VIS_MRATE)  // real + imag words, 24

// one window is COUNT x PASSES samples
`define VIS_PASSES 8                       // full sweeps per window

// ------------------------------------------------------------
// address widths
// ------------------------------------------------------------
`define VIS_CBITS  5                       // word address, covers COUNT
`define VIS_HBITS  (`VIS_CBITS + 2)        // host byte address

`endif

//--- source/vis_data_pkg.sv
`default_nettype none

`include "vis_config.svh"

// data widths shared by the accumulator, prefetcher and buffer
package vis_data_pkg;

   // 32-bit payloads
   typedef logic [31:0] vis_word_t;     // one accumulated visibility
   typedef logic [31:0] vis_sample_t;   // one pre-multiplied input sample
   typedef logic [31:0] vis_sum_t;      // running checksum, wraps mod 2^32

   // ------------------------------------------------------------
   // addresses
   // ------------------------------------------------------------
   typedef logic [`VIS_CBITS-1:0] corr_adr_t;   // correlator word address
   typedef logic [`VIS_CBITS-1:0] sram_adr_t;   // buffer word address, swizzled
   typedef logic [`VIS_HBITS-1:0] host_adr_t;   // host byte address

   // host side is byte wide
   typedef logic [7:0] host_byte_t;

endpackage

`default_nettype wire

//--- source/vis_bus_pkg.sv
`default_nettype none

// bus structs and the prefetch FSM encoding
package vis_bus_pkg;

   // ------------------------------------------------------------
   // correlator bus, prefetcher is master
   // ------------------------------------------------------------
   typedef struct packed {
      logic                    cyc;   // bus cycle in progress
      logic                    stb;   // request strobe
      vis_data_pkg::corr_adr_t adr;   // word address in the frozen bank
   } corr_req_t;

   typedef struct packed {
      logic                    ack;   // fixed one cycle after stb
      vis_data_pkg::vis_word_t dat;
   } corr_rsp_t;

   // ------------------------------------------------------------
   // host bus, read only
   // ------------------------------------------------------------
   typedef struct packed {
      logic                    stb;
      vis_data_pkg::host_adr_t adr;   // byte address, little endian in word
   } host_req_t;

   typedef struct packed {
      logic                     ack;
      vis_data_pkg::host_byte_t dat;
   } host_rsp_t;

   // prefetch sequencing
   typedef enum logic [1:0] {IDLE, FETCH, DRAIN} pf_state_t;

endpackage

`default_nettype wire

//--- source/vis_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module vis_accumulator (
   input  wire                        clk_i,
   input  wire                        reset_i,
   input  wire vis_data_pkg::vis_sample_t sample_i,       // pre-multiplied sample
   input  wire                        sample_valid_i,
   input  wire vis_bus_pkg::corr_req_t    corr_req_i,     // reads of the frozen bank
   output vis_bus_pkg::corr_rsp_t     corr_rsp_o,
   output logic                       switch_o            // one cycle after the swap
);

   import vis_data_pkg::*;
   import vis_bus_pkg::*;

   localparam int PASS_BITS = $clog2(`VIS_PASSES);

   // two banks, sel_q picks the one being accumulated
   vis_word_t            bank_q [2][`VIS_COUNT];
   logic                 sel_q;             // active bank
   corr_adr_t            ptr_q;             // round-robin word pointer
   logic [PASS_BITS-1:0] pass_q;            // sweeps done in this window

   logic                 last_word;
   logic                 last_pass;

   logic                 ack_q;
   vis_word_t            dat_q;

   assign last_word = (ptr_q == corr_adr_t'(`VIS_COUNT - 1));
   assign last_pass = (pass_q == PASS_BITS'(`VIS_PASSES - 1));

   // ------------------------------------------------------------
   // accumulate and swap
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < `VIS_COUNT; i++) begin
               bank_q[b][i] <= '0;
            end
         end
         sel_q    <= 1'b0;
         ptr_q    <= '0;
         pass_q   <= '0;
         switch_o <= 1'b0;
      end else begin
         switch_o <= 1'b0;                  // pulse by default low
         if (sample_valid_i) begin
            bank_q[sel_q][ptr_q] <= bank_q[sel_q][ptr_q] + sample_i;
            if (last_word) begin
               ptr_q <= '0;
               if (last_pass) begin
                  // window done, the bank just filled becomes frozen
                  pass_q   <= '0;
                  sel_q    <= !sel_q;
                  switch_o <= 1'b1;
                  for (int i = 0; i < `VIS_COUNT; i++) begin
                     bank_q[!sel_q][i] <= '0;   // old frozen bank starts fresh
                  end
               end else begin
                  pass_q <= pass_q + 1'b1;
               end
            end else begin
               ptr_q <= ptr_q + 1'b1;
            end
         end
      end
   end

   // ------------------------------------------------------------
   // read port, frozen bank only
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= corr_req_i.cyc && corr_req_i.stb;   // fixed one cycle latency
      end
   end

   always_ff @(posedge clk_i) begin
      dat_q <= bank_q[!sel_q][corr_req_i.adr];        // payload, no reset
   end

   assign corr_rsp_o = '{ack: ack_q, dat: dat_q};

   // prefetcher must stay inside the word range
   a_adr_range: assert property (@(posedge clk_i) disable iff (reset_i)
      corr_req_i.cyc && corr_req_i.stb |-> corr_req_i.adr < corr_adr_t'(`VIS_COUNT));

endmodule

`default_nettype wire

//--- source/vis_prefetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module vis_prefetch (
   input  wire                          clk_i,
   input  wire                          reset_i,
   input  wire                          switch_i,      // banks just swapped
   output vis_bus_pkg::corr_req_t       corr_req_o,
   input  wire vis_bus_pkg::corr_rsp_t  corr_rsp_i,
   output logic                         wr_stb_o,      // buffer write
   output vis_data_pkg::sram_adr_t      wr_adr_o,
   output vis_data_pkg::vis_word_t      wr_dat_o,
   output logic                         available_o,   // buffer holds a full window
   output vis_data_pkg::vis_sum_t       checksum_o
);

   import vis_data_pkg::*;
   import vis_bus_pkg::*;

   pf_state_t state_q;
   logic      req_q;                // cyc/stb level
   corr_adr_t adr_q;                // next correlator address
   logic      pend_vld_q;           // one-stage queue of in-flight reads
   sram_adr_t pend_adr_q;           // swizzled target of the pending read
   logic      take;                 // ack that lands in the buffer

   // real/imag pair of each slot placed side by side
   function automatic sram_adr_t swizzle(input corr_adr_t adr);
      int unsigned corr;
      int unsigned part;
      int unsigned slot;
      corr = adr / (2 * `VIS_MRATE);
      part = (adr % (2 * `VIS_MRATE)) / `VIS_MRATE;   // 0 real, 1 imag
      slot = adr % `VIS_MRATE;
      return sram_adr_t'((corr * `VIS_MRATE + slot) * 2 + part);
   endfunction

   // ------------------------------------------------------------
   // request FSM
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q     <= IDLE;
         req_q       <= 1'b0;
         adr_q       <= '0;
         available_o <= 1'b0;
      end else if (switch_i) begin
         state_q     <= FETCH;      // also restarts a fetch in progress
         req_q       <= 1'b1;
         adr_q       <= '0;
         available_o <= 1'b0;
      end else begin
         case (state_q)
            FETCH: begin
               if (adr_q == corr_adr_t'(`VIS_COUNT - 1)) begin
                  state_q <= DRAIN;   // last request is on the bus
                  req_q   <= 1'b0;
               end else begin
                  adr_q <= adr_q + 1'b1;
               end
            end
            DRAIN: begin
               state_q     <= IDLE;   // last ack written this edge
               available_o <= 1'b1;
            end
            default: begin
               req_q <= 1'b0;
            end
         endcase
      end
   end

   assign corr_req_o = '{cyc: req_q, stb: req_q, adr: adr_q};

   // ------------------------------------------------------------
   // pending queue and checksum
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (reset_i || switch_i) begin
         pend_vld_q <= 1'b0;        // drop reads of an abandoned fetch
         checksum_o <= '0;
      end else begin
         pend_vld_q <= req_q;
         if (take) begin
            checksum_o <= checksum_o + corr_rsp_i.dat;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      pend_adr_q <= swizzle(adr_q);
   end

   assign take     = corr_rsp_i.ack && pend_vld_q;
   assign wr_stb_o = take;
   assign wr_adr_o = pend_adr_q;
   assign wr_dat_o = corr_rsp_i.dat;

   // every ack meets a queued read unless it is the tail of an abandoned fetch
   a_ack_pending: assert property (@(posedge clk_i) disable iff (reset_i)
      corr_rsp_i.ack && !$past(switch_i) |-> pend_vld_q);

endmodule

`default_nettype wire

//--- source/vis_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module vis_sram (
   input  wire                          clk_i,
   input  wire                          wr_stb_i,     // whole-word write
   input  wire vis_data_pkg::sram_adr_t wr_adr_i,
   input  wire vis_data_pkg::vis_word_t wr_dat_i,
   input  wire vis_bus_pkg::host_req_t  host_req_i,   // byte reads from the host
   output vis_bus_pkg::host_rsp_t       host_rsp_o
);

   import vis_data_pkg::*;
   import vis_bus_pkg::*;

   vis_word_t  mem [`VIS_COUNT];

   sram_adr_t  word_adr;            // host address / 4
   logic [1:0] byte_sel;            // host address mod 4
   vis_word_t  rd_word;

   logic       ack_q;
   host_byte_t dat_q;

   // ------------------------------------------------------------
   // write port, from the prefetcher
   // ------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_stb_i) begin
         mem[wr_adr_i] <= wr_dat_i;
      end
   end

   // host port
   assign word_adr = host_req_i.adr[`VIS_HBITS-1:2];
   assign byte_sel = host_req_i.adr[1:0];
   assign rd_word  = mem[word_adr];

   always_ff @(posedge clk_i) begin
      ack_q <= host_req_i.stb;                    // ack one cycle after stb
      dat_q <= rd_word[{byte_sel, 3'b000} +: 8];  // little endian byte lane
   end

   assign host_rsp_o = '{ack: ack_q, dat: dat_q};

   // host stays inside the buffer
   a_host_range: assert property (@(posedge clk_i)
      host_req_i.stb |-> word_adr < sram_adr_t'(`VIS_COUNT));

endmodule

`default_nettype wire

//--- source/vis_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module vis_top (
   input  wire                            clk_i,
   input  wire                            reset_i,
   input  wire vis_data_pkg::vis_sample_t sample_i,
   input  wire                            sample_valid_i,
   input  wire vis_bus_pkg::host_req_t    host_req_i,
   output vis_bus_pkg::host_rsp_t         host_rsp_o,
   output logic                           switch_o,      // bank swap pulse
   output logic                           available_o,   // buffer ready for the host
   output vis_data_pkg::vis_sum_t         checksum_o
);

   import vis_data_pkg::*;
   import vis_bus_pkg::*;

   // ------------------------------------------------------------
   // correlator bus and buffer write path
   // ------------------------------------------------------------
   corr_req_t corr_req;
   corr_rsp_t corr_rsp;
   logic      wr_stb;
   sram_adr_t wr_adr;
   vis_word_t wr_dat;

   vis_accumulator u_acc (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .corr_req_i     (corr_req),
      .corr_rsp_o     (corr_rsp),
      .switch_o       (switch_o)
   );

   vis_prefetch u_pf (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .switch_i    (switch_o),     // prefetch starts on the swap pulse
      .corr_req_o  (corr_req),
      .corr_rsp_i  (corr_rsp),
      .wr_stb_o    (wr_stb),
      .wr_adr_o    (wr_adr),
      .wr_dat_o    (wr_dat),
      .available_o (available_o),
      .checksum_o  (checksum_o)
   );

   vis_sram u_sram (
      .clk_i      (clk_i),
      .wr_stb_i   (wr_stb),
      .wr_adr_i   (wr_adr),
      .wr_dat_i   (wr_dat),
      .host_req_i (host_req_i),
      .host_rsp_o (host_rsp_o)
   );

endmodule

`default_nettype wire

//--- tests/vis_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "vis_config.svh"

module vis_tb;

   import vis_data_pkg::*;
   import vis_bus_pkg::*;

   localparam int WINDOWS        = 3;
   localparam int HOST_BYTES     = `VIS_COUNT * 4;
   localparam int TIMEOUT_CYCLES = 4 * `VIS_COUNT * `VIS_PASSES * 2 + 1000;

   logic        clk_i = 1'b0;
   logic        reset_i;
   vis_sample_t sample_i;
   logic        sample_valid_i;
   host_req_t   host_req_i;
   host_rsp_t   host_rsp_o;
   logic        switch_o;
   logic        available_o;
   vis_sum_t    checksum_o;

   // ------------------------------------------------------------
   // reference model state
   // ------------------------------------------------------------
   vis_word_t   m_bank [2][`VIS_COUNT];   // mirror of both banks
   vis_word_t   model_buf [`VIS_COUNT];   // swizzled copy of the last finished window
   vis_sum_t    model_sum;
   int          m_sel = 0;
   int          m_ptr = 0;
   int          m_pass = 0;
   int          windows_model = 0;

   logic [31:0] rng = 32'hdf2ee191;
   logic        stim_on = 1'b0;
   logic        checks_on = 1'b0;
   logic        switch_exp = 1'b0;       // pulse due after this edge
   logic        avail_exp = 1'b0;
   vis_sum_t    sum_exp = '0;
   int          sw_cnt = 1000;           // cycles since the last switch pulse
   int          windows_ready = 0;
   int          cycle_cnt = 0;
   logic        host_pend = 1'b0;        // stb seen by the buffer this edge
   host_adr_t   host_pend_adr = '0;

   vis_top UUT (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .host_req_i     (host_req_i),
      .host_rsp_o     (host_rsp_o),
      .switch_o       (switch_o),
      .available_o    (available_o),
      .checksum_o     (checksum_o)
   );

   always #4 clk_i = ~clk_i;   // 8 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic abort_run();
      $display("test failed");
      $fatal(1);
   endtask

   // ------------------------------------------------------------
   // compare tasks
   // ------------------------------------------------------------
   task automatic check_byte(input string name, input host_byte_t got, input host_byte_t exp);
      if (got !== exp) begin
         $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_sum(input string name, input vis_sum_t got, input vis_sum_t exp);
      if (got !== exp) begin
         $display("Error: time %0t, %s = %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: time %0t, %s = %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   // copy the finished bank into the buffer layout with real/imag pairs side by side
   task automatic freeze_window(input int bank);
      int cadr;
      int sadr;
      model_sum = '0;
      for (int c = 0; c < `VIS_CORRS; c++) begin
         for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < `VIS_MRATE; s++) begin
               cadr = c * 2 * `VIS_MRATE + p * `VIS_MRATE + s;
               sadr = (c * `VIS_MRATE + s) * 2 + p;
               model_buf[sadr] = m_bank[bank][cadr];
               model_sum       = model_sum + m_bank[bank][cadr];
            end
         end
      end
   endtask

   task automatic model_take(input vis_sample_t s);
      m_bank[m_sel][m_ptr] = m_bank[m_sel][m_ptr] + s;
      if (m_ptr == `VIS_COUNT - 1) begin
         m_ptr = 0;
         if (m_pass == `VIS_PASSES - 1) begin   // window end swaps the banks
            m_pass = 0;
            freeze_window(m_sel);
            m_sel = 1 - m_sel;
            for (int i = 0; i < `VIS_COUNT; i++) begin
               m_bank[m_sel][i] = '0;
            end
            switch_exp    = 1'b1;
            windows_model = windows_model + 1;
         end else begin
            m_pass = m_pass + 1;
         end
      end else begin
         m_ptr = m_ptr + 1;
      end
   endtask

   // ------------------------------------------------------------
   // model update, sample stimulus and timeout on each rising edge
   // ------------------------------------------------------------
   always @(posedge clk_i) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
      host_pend     = host_req_i.stb;   // values the DUT samples at this edge
      host_pend_adr = host_req_i.adr;
      switch_exp    = 1'b0;
      if (!reset_i && sample_valid_i) begin
         model_take(sample_i);
      end
      if (stim_on) begin
         rng = xorshift32(rng);
         sample_valid_i <= (rng[1:0] != 2'b00);   // about 3 in 4
         rng = xorshift32(rng);
         sample_i <= rng;
      end
   end

   // outputs are checked at the falling edge where they are stable
   always @(negedge clk_i) begin
      int lane;
      if (checks_on) begin
         check_bit("switch_o", switch_o, switch_exp);
         if (switch_o) begin
            sw_cnt = 0;
         end else if (sw_cnt < 1000) begin
            sw_cnt = sw_cnt + 1;
         end
         if (sw_cnt == 1) begin                    // dropped on the switch edge
            avail_exp = 1'b0;
            check_sum("checksum_o", checksum_o, '0);
         end
         if (sw_cnt == `VIS_COUNT + 2) begin
            avail_exp     = 1'b1;
            sum_exp       = model_sum;
            windows_ready = windows_ready + 1;
         end
         check_bit("available_o", available_o, avail_exp);
         if (avail_exp) begin
            check_sum("checksum_o", checksum_o, sum_exp);
         end
         check_bit("host_rsp_o.ack", host_rsp_o.ack, host_pend);
         if (host_pend) begin
            lane = int'(host_pend_adr) % 4;
            check_byte("host_rsp_o.dat", host_rsp_o.dat,
                       host_byte_t'(model_buf[int'(host_pend_adr) / 4] >> (8 * lane)));
         end
      end
   end

   // one byte per cycle over the whole buffer
   task automatic read_buffer();
      for (int a = 0; a < HOST_BYTES; a++) begin
         host_req_i <= '{stb: 1'b1, adr: host_adr_t'(a)};
         @(posedge clk_i);
      end
      host_req_i <= '0;
      @(posedge clk_i);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      reset_i        = 1'b1;
      sample_i       = '0;
      sample_valid_i = 1'b0;
      host_req_i     = '0;
      for (int b = 0; b < 2; b++) begin
         for (int i = 0; i < `VIS_COUNT; i++) begin
            m_bank[b][i] = '0;        // both banks come out of reset cleared
         end
      end
      repeat (8) @(posedge clk_i);
      reset_i <= 1'b0;
      @(negedge clk_i);
      check_bit("switch_o", switch_o, 1'b0);   // reset values
      check_bit("available_o", available_o, 1'b0);
      check_bit("host_rsp_o.ack", host_rsp_o.ack, 1'b0);
      check_sum("checksum_o", checksum_o, '0);
      @(posedge clk_i);
      checks_on = 1'b1;
      stim_on <= 1'b1;
      for (int w = 0; w < WINDOWS; w++) begin
         while (windows_ready <= w) begin
            @(posedge clk_i);
         end
         read_buffer();
      end
      @(posedge clk_i);
      if (windows_ready == WINDOWS && windows_model == WINDOWS) begin
         $display("test passed");
         $finish;
      end else begin
         $display("window count wrong: %0d prefetched, %0d in the model",
                  windows_ready, windows_model);
         abort_run();
      end
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
source/vis_data_pkg.sv
source/vis_bus_pkg.sv
source/vis_accumulator.sv
source/vis_prefetch.sv
source/vis_sram.sv
source/vis_top.sv
tests/vis_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module vis_tb -o vis_tb_sim \
   && ./obj_dir/vis_tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^test passed$" sim.log 2>/dev/null \
   && echo "simulation ok" \
   || { echo "simulation FAILED"; exit 1; }
